// ==== z80_port_ctrl.f ====
verilog/zport_pkg.sv
verilog/port_decode.sv
verilog/page_7ffd.sv
verilog/xt_regs.sv
verilog/sd_ctrl.sv
verilog/read_mux.sv
verilog/z80_port_ctrl.sv
testbench/z80_port_ctrl_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the Z80 port controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module z80_port_ctrl_tb \
    -Mdir obj_dir -f z80_port_ctrl.f; then
  echo "verilator compile failed"
  exit 1
fi

if ! ./obj_dir/Vz80_port_ctrl_tb > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi

exit 0

// ==== testbench/z80_port_ctrl_tb.sv ====
// Z80 port controller testbench
`timescale 1ns/10ps

module z80_port_ctrl_tb;

  localparam logic [7:0] MEMCONF_INIT = 8'h04;
  localparam logic [7:0] INTMASK_INIT = 8'h01;
  localparam int MAX_CYCLES = 4000; // tests take about 1100 cycles
  localparam int K_IDLE = 0, K_WR = 1, K_RD = 2, K_REG = 3, K_FETCH = 4;

  logic clk = 1'b0;
  logic rst, iord, wr, iowr_s, iord_s, regs_we, opfetch, dos, tape_read;
  logic [15:0] a;
  logic [7:0] din, mus_in, sd_dataout;
  logic [4:0] keys_in, kj_in;
  logic [7:0] dout, sd_datain;
  logic dataout, porthit, sdcs_n, sd_start;
  zport_pkg::video_strobe_t strobes;
  zport_pkg::cfg_out_t cfg;

  // shadow copy of the DUT state
  logic [3:0][7:0] sh_page;
  logic [7:0] sh_sysconf, sh_memconf, sh_intmask;
  logic [3:0] sh_cache;
  logic [4:0] sh_fmaddr;
  logic sh_armed, sh_flag, sh_lock48, sh_m1lock, sh_cs_n;

  int errors = 0, checks = 0, tests = 0, cycles = 0;
  logic check_en = 1'b0;
  logic [7:0] xt_idx [0:15] = '{8'h10, 8'h11, 8'h12, 8'h13, 8'h15, 8'h20, 8'h21, 8'h2A,
                                8'h2B, 8'h00, 8'h01, 8'h06, 8'h07, 8'h0F, 8'h22, 8'h23};
  logic [7:0] vid_idx [0:7] = '{8'h00, 8'h01, 8'h06, 8'h07, 8'h0F, 8'h22, 8'h23, 8'h24};
  logic [7:0] rd_port [0:7] = '{8'hFE, 8'hAF, 8'hFD, 8'h1F, 8'hDF, 8'h77, 8'h57, 8'h3B};

  z80_port_ctrl #(
    .MEMCONF_INIT (MEMCONF_INIT),
    .INTMASK_INIT (INTMASK_INIT)
  ) dut_i (
    .clk (clk), .rst (rst), .a (a), .din (din), .iord (iord), .wr (wr),
    .iowr_s (iowr_s), .iord_s (iord_s), .regs_we (regs_we), .opfetch (opfetch),
    .dos (dos), .keys_in (keys_in), .tape_read (tape_read), .mus_in (mus_in),
    .kj_in (kj_in), .sd_dataout (sd_dataout), .dout (dout), .dataout (dataout),
    .porthit (porthit), .strobes (strobes), .cfg (cfg), .sdcs_n (sdcs_n),
    .sd_start (sd_start), .sd_datain (sd_datain)
  );

  always #10 clk = ~clk;

  function automatic logic [7:0] high_addr();
    return regs_we ? a[7:0] : a[15:8];
  endfunction

  function automatic logic [7:0] rnd8();
    logic [31:0] v;
    v = $urandom;
    return v[7:0];
  endfunction

  function automatic logic [7:0] reference_read();
    logic [7:0] hi;
    logic [7:0] r;
    hi = high_addr();
    r = 8'hFF;
    case (a[7:0])
      8'hFE: r = {1'b1, tape_read, 1'b1, keys_in};
      8'hAF:
      begin
        if (hi == 8'h00)
          r = {1'b0, sh_flag, 6'b000000};
        else if (hi == 8'h12 || hi == 8'h13)
          r = sh_page[hi[1:0]];
      end
      8'h1F: r = dos ? 8'hFF : {3'b000, kj_in};
      8'hDF: r = mus_in;
      8'h77: r = 8'h00;
      8'h57: r = sd_dataout;
      default: r = 8'hFF;
    endcase
    return r;
  endfunction

  function automatic logic expected_hit();
    case (a[7:0])
      8'hFE, 8'hAF, 8'hFD, 8'hDF, 8'h77, 8'h57: return 1'b1;
      8'h1F: return !dos;
      default: return 1'b0;
    endcase
  endfunction

  function automatic zport_pkg::video_strobe_t expected_strobes();
    zport_pkg::video_strobe_t s;
    logic xw;
    logic [7:0] hi;
    hi = high_addr();
    xw = (a[7:0] == 8'hAF && iowr_s) || regs_we;
    s.zborder   = a[7:0] == 8'hFE && iowr_s;
    s.border    = xw && hi == 8'h0F;
    s.zvpage    = a[7:0] == 8'hFD && !a[15] && iowr_s;
    s.vpage     = xw && hi == 8'h01;
    s.vconf     = xw && hi == 8'h00;
    s.tsconf    = xw && hi == 8'h06;
    s.palsel    = xw && hi == 8'h07;
    s.hint_beg  = xw && hi == 8'h22;
    s.vint_begl = xw && hi == 8'h23;
    s.vint_begh = xw && hi == 8'h24;
    return s;
  endfunction

  task automatic reset_model();
    sh_page = {8'h00, 8'h02, 8'h05, 8'h00};
    sh_sysconf = 8'h00;
    sh_memconf = MEMCONF_INIT;
    sh_cache = 4'h0;
    sh_intmask = INTMASK_INIT;
    sh_fmaddr = 5'd0;
    {sh_armed, sh_flag, sh_lock48, sh_m1lock, sh_cs_n} = 5'b10001;
  endtask

  // apply the inputs seen at a rising edge to the shadow state
  task automatic update_model();
    logic [7:0] hi;
    logic [7:0] pg;
    logic [1:0] mode;
    logic lk;
    hi = high_addr();
    mode = sh_memconf[7:6];
    lk = (mode == 2'd2) ? sh_m1lock : sh_memconf[6];
    if (a[7:0] == 8'hFD && !a[15] && iowr_s && !sh_lock48)
    begin
      pg = {5'b00000, din[2:0]};
      if (mode == 2'd3)
        pg[5:3] = {din[5], din[7:6]};
      else if (!lk)
        pg[4:3] = din[7:6];
      sh_page[3] = pg;
      sh_memconf[0] = din[4];
      if (mode != 2'd3)
        sh_lock48 = din[5];
    end
    else if ((a[7:0] == 8'hAF && iowr_s) || regs_we)
    begin
      if (hi[7:2] == 6'b000100)
        sh_page[hi[1:0]] = din;
      case (hi)
        8'h15: sh_fmaddr = din[4:0];
        8'h20:
        begin
          sh_sysconf = din;
          sh_cache = {4{din[2]}};
        end
        8'h21: sh_memconf = din;
        8'h2A: sh_intmask = din;
        8'h2B: sh_cache = din[3:0];
        default: ;
      endcase
    end
    if (opfetch)
      sh_m1lock = (din[7] == din[6]);
    if (a[7:0] == 8'hAF && iord_s && !regs_we && hi == 8'h00)
    begin
      sh_flag = sh_armed;
      sh_armed = 1'b0;
    end
    if (a[7:0] == 8'h77 && iowr_s)
      sh_cs_n = din[1];
  endtask

  task automatic drive(input int kind, input logic [15:0] addr, input logic [7:0] data);
    logic [31:0] v;
    v = $urandom;
    a = addr;
    din = data;
    iowr_s = (kind == K_WR);
    iord_s = (kind == K_RD);
    regs_we = (kind == K_REG);
    opfetch = (kind == K_FETCH);
    iord = iord_s || (v[0] && !iowr_s);
    wr = iowr_s || (v[1] && !iord_s);
    {dos, tape_read, keys_in, kj_in, mus_in, sd_dataout} = v[29:2];
    @(posedge clk);
    update_model();
    #2;
  endtask

  task automatic check_value(input string name, input logic [79:0] got,
                             input logic [79:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %0d %s finished, %0d errors so far", tests, name, errors);
  endtask

  always @(negedge clk)
  begin
    if (check_en)
    begin
      check_value("dout", 80'(dout), 80'(reference_read()));
      check_value("porthit", 80'(porthit), 80'(expected_hit()));
      check_value("dataout", 80'(dataout), 80'(expected_hit() && iord));
      check_value("strobes", 80'(strobes), 80'(expected_strobes()));
      check_value("sd_start", 80'(sd_start), 80'(a[7:0] == 8'h57 && (iowr_s || iord_s)));
      check_value("sd_datain", 80'(sd_datain), 80'(wr ? din : 8'hFF));
      check_value("cfg", 80'(cfg), 80'({sh_sysconf, sh_memconf, sh_cache, sh_intmask,
                                         sh_fmaddr, sh_page}));
      check_value("sdcs_n", 80'(sdcs_n), 80'(sh_cs_n));
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial
  begin
    logic [7:0] v;
    logic [7:0] d;
    v = 8'($urandom(32'h3d97));
    rst = 1'b1;
    a = 16'h0000;
    {din, iord, wr, iowr_s, iord_s, regs_we, opfetch, dos} = '0;
    {keys_in, tape_read, mus_in, kj_in, sd_dataout} = '0;
    reset_model();
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    check_en = 1'b1;

    drive(K_IDLE, 16'h0000, 8'h00);
    drive(K_RD, 16'h00AF, 8'h00); // first status read
    check_value("dout[6] after first xstat", 80'(dout[6]), 80'(1'b1));
    drive(K_RD, 16'h00AF, 8'h00);
    check_value("dout[6] after second xstat", 80'(dout[6]), 80'(1'b0));
    report_test("reset and power-up status");

    repeat (200)
    begin
      v = rnd8();
      if (v[7])
        drive(K_WR, {xt_idx[v[3:0]], 8'hAF}, rnd8());
      else
        drive(K_REG, {rnd8(), xt_idx[v[3:0]]}, rnd8());
      drive(K_IDLE, {7'h09, v[4], 8'hAF}, rnd8()); // page 2 or 3 read back
    end
    report_test("extended register writes");

    for (int m = 0; m < 4; m++)
    begin
      for (int ol = 0; ol < 2; ol++)
      begin
        v = rnd8();
        drive(K_REG, 16'h0021, {2'(m), v[5:0]});
        drive(K_FETCH, 16'h0000, (ol == 1) ? {2'b11, v[5:0]} : {2'b10, v[5:0]});
        repeat (6)
        begin
          d = rnd8();
          if (m != 3)
            d[5] = 1'b0; // keep the 48K lock open
          drive(K_WR, {1'b0, v[6:0], 8'hFD}, d);
        end
        drive(K_WR, 16'hFFFD, rnd8()); // a15 high is not #7FFD
      end
    end
    drive(K_REG, 16'h0021, MEMCONF_INIT);
    drive(K_WR, 16'h7FFD, rnd8() | 8'h20); // engage 48K lock
    repeat (20) drive(K_WR, 16'h7FFD, rnd8());
    report_test("7ffd paging and locks");

    repeat (400)
    begin
      v = rnd8();
      d = (v[4:3] == 2'd0) ? 8'h00 : (v[4:3] == 2'd1) ? 8'h12 : (v[4:3] == 2'd2) ? 8'h13 : rnd8();
      drive(v[7] ? K_RD : K_IDLE, {d, rd_port[v[2:0]]}, rnd8());
    end
    report_test("port reads");

    repeat (100)
    begin
      v = rnd8();
      case (v[1:0])
        2'd0: drive(K_WR, {rnd8(), 8'h77}, rnd8());
        2'd1: drive(K_WR, {rnd8(), 8'h57}, rnd8());
        2'd2: drive(K_RD, {rnd8(), 8'h57}, rnd8());
        default: drive(K_IDLE, {rnd8(), 8'h57}, rnd8());
      endcase
    end
    report_test("sd card ports");

    repeat (100)
    begin
      v = rnd8();
      case (v[1:0])
        2'd0: drive(K_WR, {vid_idx[v[4:2]], 8'hAF}, rnd8());
        2'd1: drive(K_WR, {rnd8(), 8'hFE}, rnd8());
        2'd2: drive(K_WR, {1'b0, v[7:1], 8'hFD}, rnd8());
        default: drive(K_REG, {rnd8(), vid_idx[v[4:2]]}, rnd8());
      endcase
    end
    drive(K_IDLE, 16'h0000, 8'h00);
    report_test("video write strobes");

    check_en = 1'b0;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== verilog/z80_port_ctrl.sv ====
// Z80 I/O port controller
`timescale 1ns/10ps

module z80_port_ctrl #(
  parameter logic [7:0] MEMCONF_INIT = 8'h04,
  parameter logic [7:0] INTMASK_INIT = 8'h01
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [15:0]               a,
  input  logic [7:0]                din,
  input  logic                      iord,
  input  logic                      wr,
  input  logic                      iowr_s,
  input  logic                      iord_s,
  input  logic                      regs_we,
  input  logic                      opfetch,
  input  logic                      dos,
  input  logic [4:0]                keys_in,
  input  logic                      tape_read,
  input  logic [7:0]                mus_in,
  input  logic [4:0]                kj_in,
  input  logic [7:0]                sd_dataout,
  output logic [7:0]                dout,
  output logic                      dataout,
  output logic                      porthit,
  output zport_pkg::video_strobe_t  strobes,
  output zport_pkg::cfg_out_t       cfg,
  output logic                      sdcs_n,
  output logic                      sd_start,
  output logic [7:0]                sd_datain
);

  zport_pkg::port_sel_t sel;
  zport_pkg::page_wr_t  page_wr;
  logic [7:0]           hoa;
  logic                 xt_wr;
  logic                 xstat_rd;
  logic                 fd_wr;
  logic                 pwr_up_flag;

  port_decode decode_i (
    .a        (a),
    .regs_we  (regs_we),
    .iowr_s   (iowr_s),
    .iord_s   (iord_s),
    .iord     (iord),
    .dos      (dos),
    .sel      (sel),
    .hoa      (hoa),
    .xt_wr    (xt_wr),
    .xstat_rd (xstat_rd),
    .fd_wr    (fd_wr),
    .strobes  (strobes),
    .porthit  (porthit),
    .dataout  (dataout)
  );

  page_7ffd page_i (
    .clk          (clk),
    .rst          (rst),
    .din          (din),
    .opfetch      (opfetch),
    .fd_wr        (fd_wr),
    .memconf_mode (cfg.memconf[7:6]),
    .page_wr      (page_wr)
  );

  xt_regs #(
    .MEMCONF_INIT (MEMCONF_INIT),
    .INTMASK_INIT (INTMASK_INIT)
  ) regs_i (
    .clk         (clk),
    .rst         (rst),
    .din         (din),
    .hoa         (hoa),
    .xt_wr       (xt_wr),
    .xstat_rd    (xstat_rd),
    .page_wr     (page_wr),
    .cfg         (cfg),
    .pwr_up_flag (pwr_up_flag)
  );

  sd_ctrl sd_i (
    .clk       (clk),
    .rst       (rst),
    .din       (din),
    .wr        (wr),
    .iowr_s    (iowr_s),
    .iord_s    (iord_s),
    .sel       (sel),
    .sdcs_n    (sdcs_n),
    .sd_start  (sd_start),
    .sd_datain (sd_datain)
  );

  read_mux mux_i (
    .sel         (sel),
    .hoa         (hoa),
    .dos         (dos),
    .keys_in     (keys_in),
    .tape_read   (tape_read),
    .kj_in       (kj_in),
    .mus_in      (mus_in),
    .sd_dataout  (sd_dataout),
    .cfg         (cfg),
    .pwr_up_flag (pwr_up_flag),
    .dout        (dout)
  );

endmodule

// ==== verilog/read_mux.sv ====
// port read data mux
`timescale 1ns/10ps

module read_mux (
  input  zport_pkg::port_sel_t  sel,
  input  logic [7:0]            hoa,
  input  logic                  dos,
  input  logic [4:0]            keys_in,
  input  logic                  tape_read,
  input  logic [4:0]            kj_in,
  input  logic [7:0]            mus_in,
  input  logic [7:0]            sd_dataout,
  input  zport_pkg::cfg_out_t   cfg,
  input  logic                  pwr_up_flag,
  output logic [7:0]            dout
);

  always_comb
  begin
    dout = 8'hFF;  // unused ports float high
    if (sel.fe)
      dout = {1'b1, tape_read, 1'b1, keys_in};
    else if (sel.xt)
    begin
      if (hoa == zport_pkg::XT_XSTAT)
        dout = {1'b0, pwr_up_flag, 6'b000000};
      else if (hoa == zport_pkg::XT_RAMPAGE + 8'd2 || hoa == zport_pkg::XT_RAMPAGE + 8'd3)
        dout = cfg.xt_page[{hoa[1:0], 3'b000} +: 8];
    end
    else if (sel.kjoy && !dos)
      dout = {3'b000, kj_in};
    else if (sel.kmouse)
      dout = mus_in;
    else if (sel.sdcfg)
      dout = 8'h00;  // card present, not write protected
    else if (sel.sddat)
      dout = sd_dataout;
  end

endmodule

// ==== verilog/sd_ctrl.sv ====
// SD card port control
`timescale 1ns/10ps

module sd_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [7:0]            din,
  input  logic                  wr,
  input  logic                  iowr_s,
  input  logic                  iord_s,
  input  zport_pkg::port_sel_t  sel,
  output logic                  sdcs_n,
  output logic                  sd_start,
  output logic [7:0]            sd_datain
);

  always_ff @(posedge clk)
  begin
    if (rst)
      sdcs_n <= 1'b1;  // card deselected
    else if (sel.sdcfg && iowr_s)
      sdcs_n <= din[1];
  end

  // any access to #57 kicks one SPI byte
  assign sd_start  = sel.sddat && (iowr_s || iord_s);
  assign sd_datain = wr ? din : 8'hFF;  // read shifts out ones

  a_cs_idle_after_rst: assert property (
    @(posedge clk)
    rst |=> sdcs_n
  );

endmodule

// ==== verilog/xt_regs.sv ====
// extended configuration registers
`timescale 1ns/10ps

module xt_regs #(
  parameter logic [7:0] MEMCONF_INIT = 8'h04,
  parameter logic [7:0] INTMASK_INIT = 8'h01
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [7:0]            din,
  input  logic [7:0]            hoa,
  input  logic                  xt_wr,
  input  logic                  xstat_rd,
  input  zport_pkg::page_wr_t   page_wr,
  output zport_pkg::cfg_out_t   cfg,
  output logic                  pwr_up_flag
);

  logic [3:0][7:0] rampage;
  logic [7:0]      sysconf;
  logic [7:0]      memconf;
  logic [3:0]      cacheconf;
  logic [7:0]      intmask;
  logic [4:0]      fmaddr;
  logic            pwr_up_armed;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rampage   <= zport_pkg::RAMPAGE_RESET;
      sysconf   <= 8'h00;  // 3.5 MHz
      memconf   <= MEMCONF_INIT;
      cacheconf <= 4'h0;   // cache off
      intmask   <= INTMASK_INIT;
      fmaddr    <= 5'd0;
    end
    else if (page_wr.wr)
    begin
      // #7FFD wins over any #nnAF write in the same cycle
      memconf[0] <= page_wr.memconf0;
      rampage[3] <= page_wr.page;
    end
    else if (xt_wr)
    begin
      if (hoa[7:2] == zport_pkg::XT_RAMPAGE[7:2])
        rampage[hoa[1:0]] <= din;

      if (hoa == zport_pkg::XT_FMADDR)
        fmaddr <= din[4:0];

      if (hoa == zport_pkg::XT_SYSCONF)
      begin
        sysconf   <= din;
        cacheconf <= {4{din[2]}}; // cache follows the turbo bit
      end

      if (hoa == zport_pkg::XT_CACHECONF)
        cacheconf <= din[3:0];

      if (hoa == zport_pkg::XT_MEMCONF)
        memconf <= din;

      if (hoa == zport_pkg::XT_INTMASK)
        intmask <= din;
    end
  end

  // power-up status, reads as 1 only on the first XSTAT read
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pwr_up_armed <= 1'b1;
      pwr_up_flag  <= 1'b0;
    end
    else if (xstat_rd)
    begin
      pwr_up_flag  <= pwr_up_armed;
      pwr_up_armed <= 1'b0;
    end
  end

  always_comb
  begin
    cfg.sysconf   = sysconf;
    cfg.memconf   = memconf;
    cfg.cacheconf = cacheconf;
    cfg.intmask   = intmask;
    cfg.fmaddr    = fmaddr;
    cfg.xt_page   = rampage;
  end

  // decoder must never flag a status read during a register write
  a_no_wr_and_xstat: assert property (
    @(posedge clk) disable iff (rst)
    !(xt_wr && xstat_rd)
  );

endmodule

// ==== verilog/page_7ffd.sv ====
// 128K paging port #7FFD
`timescale 1ns/10ps

module page_7ffd (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [7:0]            din,
  input  logic                  opfetch,
  input  logic                  fd_wr,
  input  logic [1:0]            memconf_mode,
  output zport_pkg::page_wr_t   page_wr
);

  logic lock48;
  logic m1_lock128;  // follows the last opcode fetch
  logic mode2;
  logic mode3;
  logic lock128;
  logic [2:0] page_hi;

  assign mode2 = (memconf_mode == 2'b10);
  assign mode3 = (memconf_mode == 2'b11); // 1MB mode, no lock at all

  // modes 0 and 1 use memconf bit 6 directly
  assign lock128 = mode3 ? 1'b0 : (mode2 ? m1_lock128 : memconf_mode[0]);

  always_comb
  begin
    if (mode3)
      page_hi = {din[5], din[7:6]};
    else
      page_hi = {1'b0, lock128 ? 2'b00 : din[7:6]};
  end

  always_comb
  begin
    page_wr.wr       = fd_wr && !lock48;
    page_wr.memconf0 = din[4];  // ROM select
    page_wr.page     = {2'b00, page_hi, din[2:0]};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      m1_lock128 <= 1'b0;
    else if (opfetch)
      m1_lock128 <= (din[7] == din[6]);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      lock48 <= 1'b0;
    else if (page_wr.wr && !mode3)
      lock48 <= din[5];  // 48K lock
  end

  // once engaged, the 48K lock holds until reset
  a_lock48_sticky: assert property (
    @(posedge clk) disable iff (rst)
    lock48 |=> lock48
  );

endmodule

// ==== verilog/port_decode.sv ====
// Z80 I/O address decoder
`timescale 1ns/10ps

module port_decode (
  input  logic [15:0]               a,
  input  logic                      regs_we,
  input  logic                      iowr_s,
  input  logic                      iord_s,
  input  logic                      iord,
  input  logic                      dos,
  output zport_pkg::port_sel_t      sel,
  output logic [7:0]                hoa,
  output logic                      xt_wr,
  output logic                      xstat_rd,
  output logic                      fd_wr,
  output zport_pkg::video_strobe_t  strobes,
  output logic                      porthit,
  output logic                      dataout
);

  logic [7:0] loa;

  assign loa = a[7:0];
  assign hoa = regs_we ? a[7:0] : a[15:8]; // internal writes carry the index low

  always_comb
  begin
    sel.fe     = (loa == zport_pkg::PORT_FE);
    sel.xt     = (loa == zport_pkg::PORT_XT);
    sel.fd     = (loa == zport_pkg::PORT_FD);
    sel.kjoy   = (loa == zport_pkg::PORT_KJOY);
    sel.kmouse = (loa == zport_pkg::PORT_KMOUSE);
    sel.sdcfg  = (loa == zport_pkg::PORT_SDCFG);
    sel.sddat  = (loa == zport_pkg::PORT_SDDAT);
  end

  // joystick is hidden while DOS is paged in
  assign porthit = sel.fe || sel.xt || sel.fd || sel.kmouse || sel.sdcfg || sel.sddat
                || (sel.kjoy && !dos);
  assign dataout = porthit && iord;

  assign xt_wr    = (sel.xt && iowr_s) || regs_we;
  assign xstat_rd = sel.xt && iord_s && !regs_we && (hoa == zport_pkg::XT_XSTAT);
  assign fd_wr    = sel.fd && !a[15] && iowr_s; // a15 high is the AY

  always_comb
  begin
    strobes.zborder   = sel.fe && iowr_s;
    strobes.border    = xt_wr && (hoa == zport_pkg::XT_XBORDER);
    strobes.zvpage    = fd_wr;
    strobes.vpage     = xt_wr && (hoa == zport_pkg::XT_VPAGE);
    strobes.vconf     = xt_wr && (hoa == zport_pkg::XT_VCONF);
    strobes.tsconf    = xt_wr && (hoa == zport_pkg::XT_TSCONF);
    strobes.palsel    = xt_wr && (hoa == zport_pkg::XT_PALSEL);
    strobes.hint_beg  = xt_wr && (hoa == zport_pkg::XT_HSINT);
    strobes.vint_begl = xt_wr && (hoa == zport_pkg::XT_VSINTL);
    strobes.vint_begh = xt_wr && (hoa == zport_pkg::XT_VSINTH);
  end

endmodule

// ==== verilog/zport_pkg.sv ====
// Z80 port controller definitions

package zport_pkg;

  // low address bytes of the internal ports
  localparam logic [7:0] PORT_FE     = 8'hFE; // keyboard, tape, border
  localparam logic [7:0] PORT_XT     = 8'hAF; // extended registers #nnAF
  localparam logic [7:0] PORT_FD     = 8'hFD; // #7FFD paging
  localparam logic [7:0] PORT_KJOY   = 8'h1F; // kempston joystick
  localparam logic [7:0] PORT_KMOUSE = 8'hDF; // kempston mouse
  localparam logic [7:0] PORT_SDCFG  = 8'h77; // SD config
  localparam logic [7:0] PORT_SDDAT  = 8'h57; // SD data

  // high address indices behind #nnAF
  localparam logic [7:0] XT_VCONF     = 8'h00;
  localparam logic [7:0] XT_VPAGE     = 8'h01;
  localparam logic [7:0] XT_TSCONF    = 8'h06;
  localparam logic [7:0] XT_PALSEL    = 8'h07;
  localparam logic [7:0] XT_XBORDER   = 8'h0F;
  localparam logic [7:0] XT_RAMPAGE   = 8'h10; // #10..#13
  localparam logic [7:0] XT_FMADDR    = 8'h15;
  localparam logic [7:0] XT_SYSCONF   = 8'h20;
  localparam logic [7:0] XT_MEMCONF   = 8'h21;
  localparam logic [7:0] XT_HSINT     = 8'h22;
  localparam logic [7:0] XT_VSINTL    = 8'h23;
  localparam logic [7:0] XT_VSINTH    = 8'h24;
  localparam logic [7:0] XT_INTMASK   = 8'h2A;
  localparam logic [7:0] XT_CACHECONF = 8'h2B;
  localparam logic [7:0] XT_XSTAT     = 8'h00; // read side only

  // page register reset values, index 0 in the low byte
  localparam logic [3:0][7:0] RAMPAGE_RESET = {8'h00, 8'h02, 8'h05, 8'h00};

  // one bit per decoded low address
  typedef struct packed {
    logic fe;
    logic xt;
    logic fd;
    logic kjoy;
    logic kmouse;
    logic sdcfg;
    logic sddat;
  } port_sel_t;

  // write strobes towards the video block
  typedef struct packed {
    logic zborder;   // #FE write
    logic border;
    logic zvpage;    // #7FFD write
    logic vpage;
    logic vconf;
    logic tsconf;
    logic palsel;
    logic hint_beg;
    logic vint_begl;
    logic vint_begh;
  } video_strobe_t;

  // configuration register outputs
  typedef struct packed {
    logic [7:0]  sysconf;
    logic [7:0]  memconf;
    logic [3:0]  cacheconf;
    logic [7:0]  intmask;
    logic [4:0]  fmaddr;
    logic [31:0] xt_page;  // page 3 in the top byte
  } cfg_out_t;

  // counted #7FFD write with its page value
  typedef struct packed {
    logic       wr;
    logic       memconf0;
    logic [7:0] page;
  } page_wr_t;

endpackage
